/* bench/sib_props.sv */
// SampleInBall handshake assertions
module sib_props (
  input logic            clk,
  input logic            rst_b,
  input logic            zeroize_i,
  input logic            data_ready_i,
  input logic            coeff_valid_i,
  input logic            coeff_ready_i,
  input sib_pkg::coeff_t coeff_i,
  input logic            coeff_last_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned assert_fails = 0;

  // Output beat held while the sink stalls
  assert property (@(posedge clk) disable iff (!rst_b || zeroize_i)
    coeff_valid_i && !coeff_ready_i |=>
      coeff_valid_i && $stable(coeff_i) && $stable(coeff_last_i))
  else begin
    assert_fails++;
    $error("coeff_o or coeff_last_o changed under back-pressure");
  end

  // Input and output phases never overlap
  assert property (@(posedge clk) disable iff (!rst_b)
    !(coeff_valid_i && data_ready_i))
  else begin
    assert_fails++;
    $error("coeff_valid_o high while data_ready_o is high");
  end

  assert property (@(posedge clk) $rose(rst_b) |-> !coeff_valid_i)
  else begin
    assert_fails++;
    $error("coeff_valid_o high right after reset");
  end

endmodule

bind sib_top sib_props props0 (
  .clk           (clk),
  .rst_b         (rst_b),
  .zeroize_i     (zeroize_i),
  .data_ready_i  (data_ready_o),
  .coeff_valid_i (coeff_valid_o),
  .coeff_ready_i (coeff_ready_i),
  .coeff_i       (coeff_o),
  .coeff_last_i  (coeff_last_o)
);

/* bench/sib_tb.sv */
// SampleInBall testbench
module sib_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import sib_pkg::*;

  localparam int tau         = 39;
  localparam int n_seeds     = 10;
  localparam int seed_cycles = 4000;

  logic      clk;
  logic      rst_b;
  logic      zeroize;
  logic      data_valid;
  logic      data_ready;
  sib_word_t data;
  logic      coeff_valid;
  logic      coeff_ready;
  coeff_t    coeff;
  logic      coeff_last;

  // Reference model of the challenge polynomial
  coeff_t      model_c [sib_num_coeff];
  logic [63:0] model_sign;
  int          model_pos;
  int          model_acc;
  int          model_words;

  logic [31:0] rng;
  int          errors;
  int          out_idx;
  int          out_nonzero;
  int          words_xfer;
  int          words_multi;
  int          words_none;

  sib_top #(
    .TAU(tau)
  ) dut0 (
    .clk           (clk),
    .rst_b         (rst_b),
    .zeroize_i     (zeroize),
    .data_valid_i  (data_valid),
    .data_ready_o  (data_ready),
    .data_i        (data),
    .coeff_valid_o (coeff_valid),
    .coeff_ready_i (coeff_ready),
    .coeff_o       (coeff),
    .coeff_last_o  (coeff_last)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    repeat ((n_seeds + 1) * seed_cycles) @(posedge clk);
    $display("Timeout: run still busy after %0d cycles", (n_seeds + 1) * seed_cycles);
    $display("** FAIL **");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Random word, with some lanes or whole words pushed to 0xff
  function automatic sib_word_t random_word();
    sib_word_t w;
    rng = xorshift32(rng);
    w   = rng;
    rng = xorshift32(rng);
    if (rng[2:0] == 3'b000) begin
      w = '1;
    end
    for (int k = 0; k < sib_lanes; k++) begin
      if (rng[8+2*k +: 2] == 2'b00) begin
        w[8*k +: 8] = 8'hff;
      end
    end
    return w;
  endfunction

  task automatic model_clear();
    foreach (model_c[n]) begin
      model_c[n] = coeff_zero;
    end
    model_sign  = '0;
    model_pos   = sib_num_coeff - tau;
    model_acc   = 0;
    model_words = 0;
  endtask

  // Two sign words, then each byte is a candidate j for position i
  task automatic model_word(input sib_word_t w);
    int j;
    int hits;
    hits = 0;
    if (model_acc < tau) begin
      if (model_words == 0) begin
        model_sign[31:0] = w;
      end else if (model_words == 1) begin
        model_sign[63:32] = w;
      end else begin
        for (int k = 0; k < sib_lanes && model_acc < tau; k++) begin
          j = int'(w[8*k +: 8]);
          if (j <= model_pos) begin
            model_c[model_pos] = model_c[j];
            model_c[j] = model_sign[model_acc] ? coeff_neg : coeff_pos;
            model_acc++;
            model_pos++;
            hits++;
          end
        end
        if (hits == 0) begin
          words_none++;
        end
        if (hits > 1) begin
          words_multi++;
        end
      end
      model_words++;
    end
  endtask

  task automatic check_coeff();
    logic exp_last;
    exp_last = (out_idx == sib_num_coeff - 1);
    if (out_idx >= sib_num_coeff) begin
      errors++;
      $display("Coefficient streamed after the last one");
    end else begin
      if (coeff !== model_c[out_idx]) begin
        errors++;
        $display("Fail coeff_o[%0d]: expected %h, got %h", out_idx, model_c[out_idx], coeff);
      end
      if (coeff_last !== exp_last) begin
        errors++;
        $display("Fail coeff_last_o[%0d]: expected %h, got %h", out_idx, exp_last, coeff_last);
      end
      if (coeff != coeff_zero) begin
        out_nonzero++;
      end
    end
    out_idx++;
  endtask

  // One clock: sample handshakes mid-cycle, drive just after the edge
  task automatic step(input bit feed);
    logic in_xfer;
    logic out_xfer;
    @(negedge clk);
    in_xfer  = data_valid && data_ready;
    out_xfer = coeff_valid && coeff_ready;
    if (coeff_valid && model_acc < tau) begin
      errors++;
      $display("Coefficient output started before the last swap was handed over");
    end
    if (in_xfer) begin
      words_xfer++;
      model_word(data);
    end
    if (out_xfer) begin
      check_coeff();
    end
    @(posedge clk);
    #1;
    rng = xorshift32(rng);
    coeff_ready = (rng[1:0] != 2'b00);
    // Words keep coming after the last swap and must stay untaken
    if (in_xfer || !data_valid) begin
      data_valid = feed && (rng[3:2] != 2'b00);
      if (data_valid) begin
        data = random_word();
      end
    end
  endtask

  task automatic run_seed();
    model_clear();
    out_idx     = 0;
    out_nonzero = 0;
    words_xfer  = 0;
    while (out_idx < sib_num_coeff) begin
      step(1'b1);
    end
    data_valid = 1'b0;
    // Input side reopens after coefficient 255
    while (!data_ready) begin
      step(1'b0);
    end
    if (out_nonzero != tau) begin
      errors++;
      $display("Fail nonzero count: expected %h, got %h", tau, out_nonzero);
    end
    if (words_xfer != model_words) begin
      errors++;
      $display("Fail data_i word count: expected %h, got %h", model_words, words_xfer);
    end
  endtask

  // Zeroize partway through the input phase
  task automatic abort_seed();
    model_clear();
    repeat (12) begin
      step(1'b1);
    end
    data_valid = 1'b0;
    zeroize    = 1'b1;
    @(posedge clk);
    #1;
    zeroize = 1'b0;
    repeat (4) begin
      @(negedge clk);
      if (data_ready !== 1'b1) begin
        errors++;
        $display("Fail data_ready_o after zeroize: expected 1, got %h", data_ready);
      end
      if (coeff_valid !== 1'b0) begin
        errors++;
        $display("Fail coeff_valid_o after zeroize: expected 0, got %h", coeff_valid);
      end
    end
  endtask

  initial begin
    int total;
    rng         = 32'hd04f;
    errors      = 0;
    words_multi = 0;
    words_none  = 0;
    rst_b       = 1'b0;
    zeroize     = 1'b0;
    data_valid  = 1'b0;
    data        = '0;
    coeff_ready = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_b = 1'b1;
    @(negedge clk);
    if (data_ready !== 1'b1) begin
      errors++;
      $display("Fail data_ready_o after reset: expected 1, got %h", data_ready);
    end
    if (coeff_valid !== 1'b0) begin
      errors++;
      $display("Fail coeff_valid_o after reset: expected 0, got %h", coeff_valid);
    end
    for (int s = 0; s < n_seeds; s++) begin
      if (s == n_seeds / 2) begin
        abort_seed();
      end
      run_seed();
    end
    if (words_none == 0 || words_multi == 0) begin
      errors++;
      $display("Stimulus lacked either fully rejected or multi-lane words");
    end
    total = errors + int'(dut0.props0.assert_fails);
    $display("Done: %0d check errors, %0d assertion failures, %0d multi-lane, %0d empty words",
             errors, dut0.props0.assert_fails, words_multi, words_none);
    if (total == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* files.f */
src/sib_pkg.sv
src/sib_ctrl.sv
src/sib_shuffler.sv
src/sib_coeff_mem.sv
src/sib_readout.sv
src/sib_top.sv
bench/sib_props.sv
bench/sib_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the SampleInBall testbench with Verilator and run it
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --timescale 1ns/1ps --top-module sib_tb \
    -f files.f -o sib_sim &&
  ./obj_dir/sib_sim | tee /dev/stderr | grep -F "** PASS **" > /dev/null &&
  echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }

/* src/sib_coeff_mem.sv */
// Challenge coefficient store
module sib_coeff_mem (
  input  logic                clk,
  input  logic                rst_b,
  input  logic                zeroize_i,
  input  logic                rd_en_i,
  input  sib_pkg::coeff_idx_t rd_addr_i,
  output sib_pkg::coeff_t     rd_data_o,
  input  logic                wr_en_i,
  input  sib_pkg::coeff_idx_t wr_i_addr_i,
  input  sib_pkg::coeff_t     wr_i_data_i,
  input  sib_pkg::coeff_idx_t wr_j_addr_i,
  input  sib_pkg::coeff_t     wr_j_data_i,
  input  logic                dr_en_i,
  input  sib_pkg::coeff_idx_t dr_addr_i,
  output sib_pkg::coeff_t     dr_data_o
);
  import sib_pkg::*;

  coeff_t mem_q [sib_num_coeff];

  // Last assignment wins, so j beats i and i beats the drain clear
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      for (int n = 0; n < sib_num_coeff; n++) begin
        mem_q[n] <= coeff_zero;
      end
    end else if (zeroize_i) begin
      for (int n = 0; n < sib_num_coeff; n++) begin
        mem_q[n] <= coeff_zero;
      end
    end else begin
      if (dr_en_i) begin
        mem_q[dr_addr_i] <= coeff_zero;
      end
      if (wr_en_i) begin
        mem_q[wr_i_addr_i] <= wr_i_data_i;
        mem_q[wr_j_addr_i] <= wr_j_data_i;
      end
    end
  end

  // Both read ports have one cycle of latency
  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      rd_data_o <= mem_q[rd_addr_i];
    end
    if (dr_en_i) begin
      dr_data_o <= mem_q[dr_addr_i];
    end
  end

endmodule

/* src/sib_ctrl.sv */
// SampleInBall input controller
module sib_ctrl #(
  parameter int TAU = 39
) (
  input  logic                clk,
  input  logic                rst_b,
  input  logic                zeroize_i,
  input  logic                data_valid_i,
  output logic                data_ready_o,
  input  sib_pkg::sib_word_t  data_i,
  output logic                shuf_valid_o,
  input  logic                shuf_ready_i,
  output sib_pkg::coeff_idx_t shuf_i_o,
  output sib_pkg::coeff_idx_t shuf_j_o,
  output logic                shuf_sign_o,
  input  logic                shuf_idle_i,
  output logic                drain_start_o,
  input  logic                drain_done_i
);
  import sib_pkg::*;

  localparam int         word_w     = $bits(sib_word_t);
  localparam int         lane_sel_w = $clog2(sib_lanes);
  localparam coeff_idx_t pos_init   = coeff_idx_t'(sib_num_coeff - TAU);
  localparam coeff_idx_t pos_last   = coeff_idx_t'(sib_num_coeff - 1);

  sib_state_e state_q;
  sib_state_e state_d;

  logic [2*word_w-1:0]     sign_q;
  coeff_idx_t              pos_q;
  logic [sib_lanes-1:0]    mask_q;
  logic [sib_sample_w-1:0] lane [sib_lanes];
  logic [sib_lanes-1:0]    cand;
  logic [sib_lanes-1:0]    thru;
  logic [sib_sample_w:0]   pos_next;
  logic [lane_sel_w-1:0]   sel;
  logic                    found;
  logic                    more;
  logic                    accept;
  logic                    last_acc;
  logic                    word_xfer;

  // Lowest unmasked lane that passes the rejection test
  always_comb begin
    pos_next = {1'b0, pos_q} + 1'b1;
    found    = 1'b0;
    sel      = '0;
    for (int k = 0; k < sib_lanes; k++) begin
      lane[k] = data_i[k*sib_sample_w +: sib_sample_w];
      cand[k] = !mask_q[k] && (lane[k] <= pos_q);
      if (cand[k] && !found) begin
        found = 1'b1;
        sel   = k[lane_sel_w-1:0];
      end
    end
    // Lanes up to sel are used up; a later lane may still pass at pos+1
    thru = '0;
    more = 1'b0;
    for (int k = 0; k < sib_lanes; k++) begin
      thru[k] = (k <= int'(sel));
      if (k > int'(sel) && !mask_q[k] && ({1'b0, lane[k]} <= pos_next)) begin
        more = 1'b1;
      end
    end
  end

  assign shuf_valid_o = (state_q == SIB_ACTIVE) && data_valid_i && found;
  assign shuf_i_o     = pos_q;
  assign shuf_j_o     = lane[sel];
  assign shuf_sign_o  = sign_q[0];
  assign accept       = shuf_valid_o && shuf_ready_i;
  assign last_acc     = accept && (pos_q == pos_last);

  // Hold the word until no lane of it can be accepted any more
  always_comb begin
    unique case (state_q)
      SIB_SIGN_LO, SIB_SIGN_HI: data_ready_o = 1'b1;
      SIB_ACTIVE:               data_ready_o = !found || (accept && (!more || last_acc));
      default:                  data_ready_o = 1'b0;
    endcase
  end

  assign word_xfer = data_valid_i && data_ready_o;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      SIB_IDLE:    state_d = SIB_SIGN_LO;
      SIB_SIGN_LO: if (word_xfer) state_d = SIB_SIGN_HI;
      SIB_SIGN_HI: if (word_xfer) state_d = SIB_ACTIVE;
      SIB_ACTIVE:  if (last_acc) state_d = SIB_FLUSH;
      SIB_FLUSH:   if (shuf_idle_i) state_d = SIB_OUTPUT;
      SIB_OUTPUT:  if (drain_done_i) state_d = SIB_IDLE;
      default:     state_d = SIB_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state_q       <= SIB_SIGN_LO;
      drain_start_o <= 1'b0;
    end else if (zeroize_i) begin
      state_q       <= SIB_SIGN_LO;
      drain_start_o <= 1'b0;
    end else begin
      state_q       <= state_d;
      drain_start_o <= (state_q == SIB_FLUSH) && shuf_idle_i;
    end
  end

  // Sign buffer, position and lane mask; rearmed in SIB_IDLE
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      sign_q <= '0;
      pos_q  <= pos_init;
      mask_q <= '0;
    end else if (zeroize_i || state_q == SIB_IDLE) begin
      sign_q <= '0;
      pos_q  <= pos_init;
      mask_q <= '0;
    end else begin
      if (state_q == SIB_SIGN_LO && word_xfer) begin
        sign_q[word_w-1:0] <= data_i;
      end else if (state_q == SIB_SIGN_HI && word_xfer) begin
        sign_q[2*word_w-1:word_w] <= data_i;
      end else if (accept) begin
        sign_q <= sign_q >> 1;
      end
      if (accept) begin
        pos_q <= pos_q + 1'b1;
      end
      if (state_q == SIB_ACTIVE && word_xfer) begin
        mask_q <= '0;
      end else if (accept) begin
        mask_q <= mask_q | thru;
      end
    end
  end

endmodule

/* src/sib_pkg.sv */
// SampleInBall shared definitions
package sib_pkg;

  // Polynomial and input stream geometry
  localparam int sib_num_coeff = 256;
  localparam int sib_lanes     = 4;
  localparam int sib_sample_w  = 8;

  // Two-bit signed coefficient
  typedef logic [1:0] coeff_t;

  localparam coeff_t coeff_zero = 2'b00;
  localparam coeff_t coeff_pos  = 2'b01;
  localparam coeff_t coeff_neg  = 2'b11;

  typedef logic [$clog2(sib_num_coeff)-1:0] coeff_idx_t;

  // Lane k sits in bits 8k+7 down to 8k
  typedef logic [sib_lanes*sib_sample_w-1:0] sib_word_t;

  // Input controller states
  typedef enum logic [2:0] {
    SIB_IDLE,
    SIB_SIGN_LO,
    SIB_SIGN_HI,
    SIB_ACTIVE,
    SIB_FLUSH,
    SIB_OUTPUT
  } sib_state_e;

endpackage

/* src/sib_readout.sv */
// Coefficient output streamer
module sib_readout (
  input  logic                clk,
  input  logic                rst_b,
  input  logic                zeroize_i,
  input  logic                start_i,
  output logic                done_o,
  output logic                dr_en_o,
  output sib_pkg::coeff_idx_t dr_addr_o,
  input  sib_pkg::coeff_t     dr_data_i,
  output logic                coeff_valid_o,
  input  logic                coeff_ready_i,
  output sib_pkg::coeff_t     coeff_o,
  output logic                coeff_last_o
);
  import sib_pkg::*;

  localparam coeff_idx_t last_idx = coeff_idx_t'(sib_num_coeff - 1);

  coeff_idx_t idx_q;
  logic       active_q;
  logic       xfer;

  assign xfer = coeff_valid_o && coeff_ready_i;

  // Only read when the output slot is empty or draining this cycle
  assign dr_en_o   = active_q && (!coeff_valid_o || coeff_ready_i);
  assign dr_addr_o = idx_q;

  // Drain register in the store holds the current coefficient
  assign coeff_o = dr_data_i;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      active_q      <= 1'b0;
      idx_q         <= '0;
      coeff_valid_o <= 1'b0;
      coeff_last_o  <= 1'b0;
      done_o        <= 1'b0;
    end else if (zeroize_i) begin
      active_q      <= 1'b0;
      idx_q         <= '0;
      coeff_valid_o <= 1'b0;
      coeff_last_o  <= 1'b0;
      done_o        <= 1'b0;
    end else begin
      done_o <= xfer && coeff_last_o;
      if (start_i) begin
        active_q <= 1'b1;
        idx_q    <= '0;
      end else if (dr_en_o) begin
        idx_q <= idx_q + 1'b1;
        if (idx_q == last_idx) begin
          active_q <= 1'b0;
        end
      end
      if (dr_en_o) begin
        coeff_valid_o <= 1'b1;
        coeff_last_o  <= (idx_q == last_idx);
      end else if (xfer) begin
        coeff_valid_o <= 1'b0;
        coeff_last_o  <= 1'b0;
      end
    end
  end

endmodule

/* src/sib_shuffler.sv */
// Fisher-Yates swap engine
module sib_shuffler (
  input  logic                clk,
  input  logic                rst_b,
  input  logic                zeroize_i,
  input  logic                valid_i,
  output logic                ready_o,
  input  sib_pkg::coeff_idx_t i_i,
  input  sib_pkg::coeff_idx_t j_i,
  input  logic                sign_i,
  output logic                idle_o,
  output logic                rd_en_o,
  output sib_pkg::coeff_idx_t rd_addr_o,
  input  sib_pkg::coeff_t     rd_data_i,
  output logic                wr_en_o,
  output sib_pkg::coeff_idx_t wr_i_addr_o,
  output sib_pkg::coeff_t     wr_i_data_o,
  output sib_pkg::coeff_idx_t wr_j_addr_o,
  output sib_pkg::coeff_t     wr_j_data_o
);
  import sib_pkg::*;

  logic       rd_pend_q;
  logic       wr_pend_q;
  logic       take;
  coeff_idx_t i_q;
  coeff_idx_t j_q;
  logic       sign_q;

  // A new item may enter while the previous swap is being written;
  // its read lands one edge after that write
  assign ready_o = !rd_pend_q;
  assign idle_o  = !rd_pend_q && !wr_pend_q;
  assign take    = valid_i && ready_o;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      rd_pend_q <= 1'b0;
      wr_pend_q <= 1'b0;
    end else if (zeroize_i) begin
      rd_pend_q <= 1'b0;
      wr_pend_q <= 1'b0;
    end else begin
      rd_pend_q <= take;
      wr_pend_q <= rd_pend_q;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      i_q    <= i_i;
      j_q    <= j_i;
      sign_q <= sign_i;
    end
  end

  // Step one reads c[j]
  assign rd_en_o   = rd_pend_q;
  assign rd_addr_o = j_q;

  // Step two moves old c[j] to c[i] and puts the sign at c[j]
  assign wr_en_o     = wr_pend_q;
  assign wr_i_addr_o = i_q;
  assign wr_i_data_o = rd_data_i;
  assign wr_j_addr_o = j_q;
  assign wr_j_data_o = sign_q ? coeff_neg : coeff_pos;

endmodule

/* src/sib_top.sv */
// SampleInBall subsystem top
module sib_top #(
  parameter int TAU = 39
) (
  input  logic               clk,
  input  logic               rst_b,
  input  logic               zeroize_i,
  input  logic               data_valid_i,
  output logic               data_ready_o,
  input  sib_pkg::sib_word_t data_i,
  output logic               coeff_valid_o,
  input  logic               coeff_ready_i,
  output sib_pkg::coeff_t    coeff_o,
  output logic               coeff_last_o
);
  import sib_pkg::*;

  // Controller to shuffler
  logic       shuf_valid;
  logic       shuf_ready;
  coeff_idx_t shuf_i;
  coeff_idx_t shuf_j;
  logic       shuf_sign;
  logic       shuf_idle;

  // Controller and readout sequencing
  logic drain_start;
  logic drain_done;

  // Store ports
  logic       rd_en;
  coeff_idx_t rd_addr;
  coeff_t     rd_data;
  logic       wr_en;
  coeff_idx_t wr_i_addr;
  coeff_t     wr_i_data;
  coeff_idx_t wr_j_addr;
  coeff_t     wr_j_data;
  logic       dr_en;
  coeff_idx_t dr_addr;
  coeff_t     dr_data;

  sib_ctrl #(
    .TAU(TAU)
  ) ctrl0 (
    .clk           (clk),
    .rst_b         (rst_b),
    .zeroize_i     (zeroize_i),
    .data_valid_i  (data_valid_i),
    .data_ready_o  (data_ready_o),
    .data_i        (data_i),
    .shuf_valid_o  (shuf_valid),
    .shuf_ready_i  (shuf_ready),
    .shuf_i_o      (shuf_i),
    .shuf_j_o      (shuf_j),
    .shuf_sign_o   (shuf_sign),
    .shuf_idle_i   (shuf_idle),
    .drain_start_o (drain_start),
    .drain_done_i  (drain_done)
  );

  sib_shuffler shuf0 (
    .clk         (clk),
    .rst_b       (rst_b),
    .zeroize_i   (zeroize_i),
    .valid_i     (shuf_valid),
    .ready_o     (shuf_ready),
    .i_i         (shuf_i),
    .j_i         (shuf_j),
    .sign_i      (shuf_sign),
    .idle_o      (shuf_idle),
    .rd_en_o     (rd_en),
    .rd_addr_o   (rd_addr),
    .rd_data_i   (rd_data),
    .wr_en_o     (wr_en),
    .wr_i_addr_o (wr_i_addr),
    .wr_i_data_o (wr_i_data),
    .wr_j_addr_o (wr_j_addr),
    .wr_j_data_o (wr_j_data)
  );

  sib_coeff_mem mem0 (
    .clk         (clk),
    .rst_b       (rst_b),
    .zeroize_i   (zeroize_i),
    .rd_en_i     (rd_en),
    .rd_addr_i   (rd_addr),
    .rd_data_o   (rd_data),
    .wr_en_i     (wr_en),
    .wr_i_addr_i (wr_i_addr),
    .wr_i_data_i (wr_i_data),
    .wr_j_addr_i (wr_j_addr),
    .wr_j_data_i (wr_j_data),
    .dr_en_i     (dr_en),
    .dr_addr_i   (dr_addr),
    .dr_data_o   (dr_data)
  );

  sib_readout rdo0 (
    .clk           (clk),
    .rst_b         (rst_b),
    .zeroize_i     (zeroize_i),
    .start_i       (drain_start),
    .done_o        (drain_done),
    .dr_en_o       (dr_en),
    .dr_addr_o     (dr_addr),
    .dr_data_i     (dr_data),
    .coeff_valid_o (coeff_valid_o),
    .coeff_ready_i (coeff_ready_i),
    .coeff_o       (coeff_o),
    .coeff_last_o  (coeff_last_o)
  );

endmodule
